// File: files.f
+incdir+hw
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/stage_ifs.sv
hw/inst_fetch.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/reg_result.sv
hw/core_top.sv
verification/core_tb.sv

// File: verification/core_testdata.txt
// Each line is one record: a tag and three fields. 4d is a memory word (address, data, 0),
// 52 an expected retirement (pc, rd, value), 43 the retire count (count, 0, 0).
4d 30000000 00500093 0  // addi x1, x0, 5
4d 30000004 00308113 0  // addi x2, x1, 3
4d 30000008 002081b3 0  // add x3, x1, x2
4d 3000000c 40118233 0  // sub x4, x3, x1
4d 30000010 123452b7 0  // lui x5, 0x12345
4d 30000014 00128013 0  // addi x0, x5, 1
4d 30000018 00500333 0  // add x6, x0, x5
4d 3000001c 00410463 0  // beq x2, x4, +8 is taken
4d 30000020 06300393 0  // addi x7, x0, 99 on the wrong path
4d 30000024 00411463 0  // bne x2, x4, +8 is not taken
4d 30000028 00300413 0  // addi x8, x0, 3
4d 3000002c 00000493 0  // addi x9, x0, 0
4d 30000030 001484b3 0  // add x9, x9, x1 heads the loop
4d 30000034 fff40413 0  // addi x8, x8, -1
4d 30000038 fe041ce3 0  // bne x8, x0, -8
4d 3000003c 00c0056f 0  // jal x10, +12
4d 30000040 06300393 0
4d 30000044 06300393 0
4d 30000048 000505b3 0  // add x11, x10, x0
4d 3000004c 0080006f 0  // jal x0, +8
4d 30000050 06300393 0
4d 30000054 ff148613 0  // addi x12, x9, -15
4d 30000058 00060463 0  // beq x12, x0, +8
4d 3000005c 06300393 0
4d 30000060 00100073 0  // ebreak
52 30000000 1 5
52 30000004 2 8
52 30000008 3 d
52 3000000c 4 8
52 30000010 5 12345000
52 30000014 0 0
52 30000018 6 12345000
52 3000001c 0 0
52 30000024 0 0
52 30000028 8 3
52 3000002c 9 0
52 30000030 9 5
52 30000034 8 2
52 30000038 0 0
52 30000030 9 a
52 30000034 8 1
52 30000038 0 0
52 30000030 9 f
52 30000034 8 0
52 30000038 0 0
52 3000003c a 30000040
52 30000048 b 30000040
52 3000004c 0 0
52 30000054 c 0
52 30000058 0 0
43 19 0 0

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_tb;
  import isa_pkg::*;

  localparam int TESTDATA_WORDS = 256;

  logic clock;
  logic reset;
  word_t araddr;
  logic arvalid;
  logic arready;
  word_t rdata;
  logic rvalid;
  logic rlast;
  logic rready;
  logic retire_valid;
  word_t retire_pc;
  reg_idx_t retire_rd;
  word_t retire_value;
  logic halted;

  word_t testdata [TESTDATA_WORDS];
  word_t mem_addr [$];
  word_t mem_data [$];
  word_t exp_pc [$];
  reg_idx_t exp_rd [$];
  word_t exp_value [$];
  word_t burst_lines [$];
  int burst_counts [$];
  int expected_count;
  int retired = 0;
  int cycles = 0;
  int cycle_limit = 0;
  logic [31:0] rng_state = 32'h8c4b;
  logic first_burst_seen = 1'b0;

  core_top DUT (
    .clock(clock),
    .reset(reset),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rvalid(rvalid),
    .rlast(rlast),
    .rready(rready),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .retire_rd(retire_rd),
    .retire_value(retire_value),
    .halted(halted)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected x%0d, actual x%0d", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Words outside the program read back as the inverted address.
  function automatic word_t mem_read(input word_t addr);
    for (int i = 0; i < mem_addr.size(); i++) begin
      if (mem_addr[i] == addr) begin
        return mem_data[i];
      end
    end
    return ~addr;
  endfunction

  task automatic count_burst(input word_t line);
    for (int i = 0; i < burst_lines.size(); i++) begin
      if (burst_lines[i] == line) begin
        burst_counts[i]++;
        return;
      end
    end
    burst_lines.push_back(line);
    burst_counts.push_back(1);
  endtask

  task automatic load_testdata();
    int i;
    i = 0;
    expected_count = -1;
    $readmemh("verification/core_testdata.txt", testdata);
    while (i < TESTDATA_WORDS && expected_count < 0) begin
      case (testdata[i])
        32'h4d: begin
          mem_addr.push_back(testdata[i + 1]);
          mem_data.push_back(testdata[i + 2]);
        end
        32'h52: begin
          exp_pc.push_back(testdata[i + 1]);
          exp_rd.push_back(testdata[i + 2][4:0]);
          exp_value.push_back(testdata[i + 3]);
        end
        32'h43: expected_count = testdata[i + 1];
        default: fail_run("The test data file holds an unknown record tag.");
      endcase
      i += 4;
    end
    if (expected_count != exp_pc.size()) begin
      fail_run("The retire count in the test data does not match its retire records.");
    end
    cycle_limit = 40 * expected_count + 200;
  endtask

  initial begin
    reset = 1'b1;
    load_testdata();
    @(negedge clock);
    check_flag("arvalid in reset", 1'b0, arvalid);
    check_flag("rready in reset", 1'b0, rready);
    check_flag("retire_valid in reset", 1'b0, retire_valid);
    check_flag("halted in reset", 1'b0, halted);
    @(negedge clock);
    reset = 1'b0;
    while (!halted) begin
      @(negedge clock);
    end
    repeat (20) @(negedge clock); // Room for a stray retirement to show up.
    for (int i = 0; i < burst_lines.size(); i++) begin
      if (burst_lines[i][31:24] != `UNCACHED_TOP_BYTE && burst_counts[i] > 1) begin
        check_word($sformatf("bursts to line %h", burst_lines[i]), 32'd1,
                   word_t'(burst_counts[i]));
      end
    end
    if (retired == expected_count) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run($sformatf("FAILED retire count: expected %0d, actual %0d",
                         expected_count, retired));
    end
  end

  // Read bus memory with random stalls on both the address and each beat.
  initial begin : bus_model
    word_t line;
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    forever begin
      @(negedge clock);
      if (!reset && arvalid) begin
        repeat ((lcg_next() >> 28) % 3) @(negedge clock);
        line = araddr;
        check_word("burst address alignment", '0,
                   word_t'(line[`OFFSET_BITS-1:0]));
        if (!first_burst_seen) begin
          check_word("first burst address", `RESET_PC, line);
          first_burst_seen = 1'b1;
        end
        count_burst(line);
        arready = 1'b1;
        @(negedge clock);
        arready = 1'b0;
        for (int beat = 0; beat < `BURST_BEATS; beat++) begin
          repeat ((lcg_next() >> 28) % 3) @(negedge clock);
          rvalid = 1'b1;
          rdata = mem_read(line + 32'(4 * beat));
          rlast = beat == `BURST_BEATS - 1;
          while (!rready) begin
            @(negedge clock); // rready seen here holds through the next rising edge.
          end
          @(negedge clock);
          rvalid = 1'b0;
          rlast = 1'b0;
        end
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && retire_valid) begin
      if (retired >= expected_count) begin
        fail_run("A retirement appeared after the expected stream had ended.");
      end else begin
        check_word($sformatf("retire %0d pc", retired), exp_pc[retired], retire_pc);
        check_reg($sformatf("retire %0d rd", retired), exp_rd[retired], retire_rd);
        check_word($sformatf("retire %0d value", retired), exp_value[retired], retire_value);
        retired++;
      end
    end
  end

  always @(negedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("Timeout: the core did not finish within %0d cycles.", cycle_limit));
    end
  end

endmodule

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic                clock,
  input  logic                reset,
  output isa_pkg::word_t      araddr,
  output logic                arvalid,
  input  logic                arready,
  input  isa_pkg::word_t      rdata,
  input  logic                rvalid,
  input  logic                rlast,
  output logic                rready,
  output logic                retire_valid,
  output isa_pkg::word_t      retire_pc,
  output isa_pkg::reg_idx_t   retire_rd,
  output isa_pkg::word_t      retire_value,
  output logic                halted
);
  import isa_pkg::*;

  logic redirect;
  word_t redirect_pc;
  logic wb_valid;
  reg_idx_t wb_rd;
  word_t wb_value;
  word_t wb_pc;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  word_t rs1_value;
  word_t rs2_value;

  fetch_if fetch_bus ();
  issue_if issue_bus ();

  inst_fetch u_fetch (
    .clock(clock),
    .reset(reset),
    .fetch_bus(fetch_bus.fetch_side),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rvalid(rvalid),
    .rlast(rlast),
    .rready(rready)
  );

  inst_decode u_decode (
    .clock(clock),
    .reset(reset),
    .fetch_bus(fetch_bus.decode_side),
    .issue_bus(issue_bus.decode_side),
    .redirect(redirect),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_value(wb_value),
    .rs1_idx(rs1_idx),
    .rs2_idx(rs2_idx),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value),
    .halted(halted)
  );

  alu_execute u_execute (
    .clock(clock),
    .reset(reset),
    .issue_bus(issue_bus.execute_side),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_value(wb_value),
    .wb_pc(wb_pc),
    .halted(halted)
  );

  reg_result u_result (
    .clock(clock),
    .reset(reset),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_value(wb_value),
    .wb_pc(wb_pc),
    .rs1_idx(rs1_idx),
    .rs2_idx(rs2_idx),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .retire_rd(retire_rd),
    .retire_value(retire_value)
  );

endmodule

`default_nettype wire

// File: hw/reg_result.sv
`timescale 1ns/1ps
`default_nettype none

module reg_result (
  input  logic                clock,
  input  logic                reset,
  input  logic                wb_valid,
  input  isa_pkg::reg_idx_t   wb_rd,
  input  isa_pkg::word_t      wb_value,
  input  isa_pkg::word_t      wb_pc,
  input  isa_pkg::reg_idx_t   rs1_idx,
  input  isa_pkg::reg_idx_t   rs2_idx,
  output isa_pkg::word_t      rs1_value,
  output isa_pkg::word_t      rs2_value,
  output logic                retire_valid,
  output isa_pkg::word_t      retire_pc,
  output isa_pkg::reg_idx_t   retire_rd,
  output isa_pkg::word_t      retire_value
);
  import isa_pkg::*;

  word_t regs [32];

  assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  always_ff @(posedge clock) begin
    if (wb_valid && wb_rd != '0) begin
      regs[wb_rd] <= wb_value;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wb_valid;
    end
  end

  // Register 0 reports zero whatever was written to it.
  always_ff @(posedge clock) begin
    if (wb_valid) begin
      retire_pc <= wb_pc;
      retire_rd <= wb_rd;
      retire_value <= (wb_rd == '0) ? '0 : wb_value;
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
  input  logic                clock,
  input  logic                reset,
  issue_if.execute_side       issue_bus,
  output logic                redirect,
  output isa_pkg::word_t      redirect_pc,
  output logic                wb_valid,
  output isa_pkg::reg_idx_t   wb_rd,
  output isa_pkg::word_t      wb_value,
  output isa_pkg::word_t      wb_pc,
  output logic                halted
);
  import isa_pkg::*;

  decoded_op_t op;
  word_t src1;
  word_t src2;
  word_t result;
  logic take;
  logic writes;
  logic stop;
  logic accept;

  assign op = issue_bus.op;

  // The slot right after a redirect was fetched down the wrong path.
  assign accept = issue_bus.valid && !redirect && !halted;
  assign stop = op.opcode inside {OP_EBREAK, OP_ILLEGAL};

  // The previous result was read too late for decode to catch it.
  assign src1 = (wb_valid && wb_rd != '0 && wb_rd == op.rs1) ? wb_value : op.rs1_value;
  assign src2 = (wb_valid && wb_rd != '0 && wb_rd == op.rs2) ? wb_value : op.rs2_value;

  always_comb begin
    result = '0;
    take = 1'b0;
    writes = 1'b1;
    case (op.opcode)
      OP_ADDI: result = src1 + op.imm;
      OP_ADD: result = src1 + src2;
      OP_SUB: result = src1 - src2;
      OP_LUI: result = op.imm;
      OP_BEQ: begin
        take = src1 == src2;
        writes = 1'b0;
      end
      OP_BNE: begin
        take = src1 != src2;
        writes = 1'b0;
      end
      OP_JAL: begin
        result = op.pc + 32'd4; // Link address.
        take = 1'b1;
      end
      default: writes = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      redirect <= 1'b0;
      wb_valid <= 1'b0;
      halted <= 1'b0;
    end else begin
      redirect <= accept && take;
      wb_valid <= accept && !stop; // A halting op does not retire.
      if (accept && stop) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      redirect_pc <= op.pc + op.imm;
      wb_rd <= writes ? op.rd : '0;
      wb_value <= result;
      wb_pc <= op.pc;
    end
  end

  a_quiet_after_halt: assert property (@(posedge clock) disable iff (reset)
    halted |=> !redirect && !wb_valid);

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  logic                clock,
  input  logic                reset,
  fetch_if.decode_side        fetch_bus,
  issue_if.decode_side        issue_bus,
  input  logic                redirect,
  input  logic                wb_valid,
  input  isa_pkg::reg_idx_t   wb_rd,
  input  isa_pkg::word_t      wb_value,
  output isa_pkg::reg_idx_t   rs1_idx,
  output isa_pkg::reg_idx_t   rs2_idx,
  input  isa_pkg::word_t      rs1_value,
  input  isa_pkg::word_t      rs2_value,
  input  logic                halted
);
  import isa_pkg::*;

  word_t inst;
  logic [2:0] funct3;
  logic [6:0] funct7;
  opcode_e opcode;
  word_t imm;
  word_t rs1_fwd;
  word_t rs2_fwd;
  logic accept;

  assign inst = fetch_bus.inst;
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1_idx = inst[19:15];
  assign rs2_idx = inst[24:20];
  assign fetch_bus.ready = !halted;
  assign accept = fetch_bus.valid && fetch_bus.ready;

  always_comb begin
    opcode = OP_ILLEGAL;
    imm = '0;
    case (inst[6:0])
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          opcode = OP_ADDI;
        end
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          opcode = OP_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          opcode = OP_SUB;
        end
      end
      OPC_LUI: begin
        opcode = OP_LUI;
        imm = {inst[31:12], 12'b0};
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000) begin
          opcode = OP_BEQ;
        end else if (funct3 == 3'b001) begin
          opcode = OP_BNE;
        end
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_JAL: begin
        opcode = OP_JAL;
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_SYSTEM: begin
        if (inst == 32'h0010_0073) begin
          opcode = OP_EBREAK;
        end
      end
      default: opcode = OP_ILLEGAL;
    endcase
  end

  // The value being written this cycle has not reached the register file yet.
  assign rs1_fwd = (wb_valid && wb_rd != '0 && wb_rd == rs1_idx) ? wb_value : rs1_value;
  assign rs2_fwd = (wb_valid && wb_rd != '0 && wb_rd == rs2_idx) ? wb_value : rs2_value;

  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      issue_bus.valid <= 1'b0;
    end else begin
      issue_bus.valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      issue_bus.op.opcode <= opcode;
      issue_bus.op.rd <= inst[11:7];
      issue_bus.op.rs1 <= rs1_idx;
      issue_bus.op.rs2 <= rs2_idx;
      issue_bus.op.rs1_value <= rs1_fwd;
      issue_bus.op.rs2_value <= rs2_fwd;
      issue_bus.op.imm <= imm;
      issue_bus.op.pc <= fetch_bus.pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module inst_fetch (
  input  logic               clock,
  input  logic               reset,
  fetch_if.fetch_side        fetch_bus,
  input  logic               redirect,
  input  isa_pkg::word_t     redirect_pc,
  output isa_pkg::word_t     araddr,
  output logic               arvalid,
  input  logic               arready,
  input  isa_pkg::word_t     rdata,
  input  logic               rvalid,
  input  logic               rlast,
  output logic               rready
);
  import isa_pkg::*;
  import fetch_pkg::*;

  fetch_state_e state;
  word_t pc;
  word_t line_addr; // Missed address, stable for the whole burst.
  word_t low_word;
  logic [$clog2(`BURST_BEATS)-1:0] beat;
  logic drop_word; // Set by a redirect that arrives during a refill.

  cache_line_t cache [`LINE_COUNT];
  cache_line_t line;

  logic [`INDEX_BITS-1:0] index;
  logic [`INDEX_BITS-1:0] fill_index;
  logic [`TAG_BITS-1:0] tag;
  logic uncached;
  logic fill_uncached;
  logic hit;
  logic slot_free;
  logic load_hit;
  logic start_miss;
  logic beat_taken;
  logic last_beat;

  assign index = pc[`OFFSET_BITS +: `INDEX_BITS];
  assign tag = pc[31 -: `TAG_BITS];
  assign line = cache[index];
  assign uncached = pc[31:24] == `UNCACHED_TOP_BYTE;
  assign hit = line.valid && line.tag == tag && !uncached;

  // The output slot can take a word when it is empty or being consumed.
  assign slot_free = !fetch_bus.valid || fetch_bus.ready;
  assign load_hit = state == LOOKUP && !redirect && slot_free && hit;
  assign start_miss = state == LOOKUP && !redirect && slot_free && !hit;

  assign beat_taken = state == REFILL && rvalid && rready;
  assign last_beat = beat_taken && rlast;
  assign fill_index = line_addr[`OFFSET_BITS +: `INDEX_BITS];
  assign fill_uncached = line_addr[31:24] == `UNCACHED_TOP_BYTE;
  assign araddr = {line_addr[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= LOOKUP;
      pc <= `RESET_PC;
      arvalid <= 1'b0;
      rready <= 1'b0;
      fetch_bus.valid <= 1'b0;
      drop_word <= 1'b0;
      beat <= '0;
    end else begin
      case (state)
        LOOKUP: begin
          if (redirect) begin
            pc <= redirect_pc;
            fetch_bus.valid <= 1'b0;
          end else if (load_hit) begin
            fetch_bus.valid <= 1'b1;
            pc <= pc + 32'd4;
          end else if (start_miss) begin
            fetch_bus.valid <= 1'b0;
            state <= REFILL;
            arvalid <= 1'b1;
            drop_word <= 1'b0;
            beat <= '0;
          end
        end
        REFILL: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
          end
          if (beat_taken) begin
            beat <= beat + 1'b1;
          end
          if (last_beat) begin
            rready <= 1'b0;
            state <= LOOKUP;
            if (!drop_word && !redirect) begin
              fetch_bus.valid <= 1'b1;
              pc <= pc + 32'd4;
            end
          end
          // The burst still runs to the end, only the word is dropped.
          if (redirect) begin
            pc <= redirect_pc;
            drop_word <= 1'b1;
          end
        end
        default: state <= LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start_miss) begin
      line_addr <= pc;
    end
    if (beat_taken && beat == '0) begin
      low_word <= rdata;
    end
    if (load_hit) begin
      fetch_bus.inst <= pc[2] ? line.data[63:32] : line.data[31:0];
      fetch_bus.pc <= pc;
    end else if (last_beat) begin
      fetch_bus.inst <= pc[2] ? rdata : low_word;
      fetch_bus.pc <= pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `LINE_COUNT; i++) begin
        cache[i].valid <= 1'b0;
      end
    end else if (last_beat && !fill_uncached) begin
      cache[fill_index] <= '{valid: 1'b1,
                             tag: line_addr[31 -: `TAG_BITS],
                             data: {rdata, low_word}};
    end
  end

  a_arvalid_held: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid);

  a_no_word_in_refill: assert property (@(posedge clock) disable iff (reset)
    state == REFILL |-> !fetch_bus.valid);

endmodule

`default_nettype wire

// File: hw/stage_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// One instruction word from fetch to decode, with a ready level back.
interface fetch_if;
  import isa_pkg::*;

  logic  valid;
  word_t inst;
  word_t pc;
  logic  ready;

  modport fetch_side (output valid, output inst, output pc, input ready);
  modport decode_side (input valid, input inst, input pc, output ready);
endinterface

// Decoded operation from decode to execute. Execute never stalls.
interface issue_if;
  import isa_pkg::*;

  logic        valid;
  decoded_op_t op;

  modport decode_side (output valid, output op);
  modport execute_side (input valid, input op);
endinterface

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

`include "core_consts.svh"

package fetch_pkg;

  typedef enum logic {
    LOOKUP,
    REFILL
  } fetch_state_e;

  typedef struct packed {
    logic                        valid;
    logic [`TAG_BITS-1:0]        tag;
    logic [(8 << `OFFSET_BITS)-1:0] data;
  } cache_line_t;

endpackage

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // Major opcode field, bits 6..0 of the instruction word.
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } major_opcode_e;

  typedef enum logic [3:0] {
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_EBREAK,
    OP_ILLEGAL
  } opcode_e;

  // Source indices ride along so that execute can forward its own result.
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_value;
    word_t    rs2_value;
    word_t    imm;
    word_t    pc;
  } decoded_op_t;

endpackage

`default_nettype wire

// File: hw/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Instruction cache geometry, with 8-byte lines and 16 of them.
`define OFFSET_BITS 3
`define INDEX_BITS 4
`define LINE_COUNT 16
`define TAG_BITS 25

// First fetch address after reset.
`define RESET_PC 32'h3000_0000

// Fetches whose address starts with this byte bypass the cache.
`define UNCACHED_TOP_BYTE 8'h0f

// Words per line refill.
`define BURST_BEATS 2

`endif
